// File: source/memPkg.sv
`default_nettype none

package memPkg;

    // one RAM location
    typedef logic [7:0] byte_t;

    // instruction or data word
    typedef logic [31:0] word_t;

    // byte index inside one access
    typedef logic [1:0] beat_t;

    // access size requested by the data side
    typedef enum logic [1:0] {
        lenByte = 2'd0,
        lenHalf = 2'd1,
        lenWord = 2'd2
    } accessLen_t;

    // controller FSM
    typedef enum logic [2:0] {
        idle       = 3'd0,
        fetchRead  = 3'd1,
        loadRead   = 3'd2,
        storeWrite = 3'd3,
        finish     = 3'd4
    } ctrlState_t;

endpackage

`default_nettype wire

// File: source/memCtrl.sv
`timescale 1ns/1ns
`default_nettype none

module memCtrl #(
    parameter int AddrWidth = 12
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       i_stall,
    input  wire                       i_fetchEn,
    input  wire [AddrWidth-1:0]       i_fetchAddr,
    input  wire                       i_dataEn,
    input  wire                       i_dataStore,
    input  memPkg::accessLen_t        i_dataLen,
    input  wire [AddrWidth-1:0]       i_dataAddr,
    output logic                      o_ramEn,
    output logic                      o_ramWe,
    output logic [AddrWidth-1:0]      o_ramAddr,
    output memPkg::beat_t             o_issueBeat,
    output logic                      o_captureEn,
    output memPkg::beat_t             o_captureBeat,
    output logic                      o_clearWord,
    output logic                      o_latchStore,
    output logic                      o_fetchDone,
    output logic                      o_dataDone
);

    memPkg::ctrlState_t state;
    logic [AddrWidth-1:0] baseAddr;
    memPkg::beat_t beat;
    memPkg::beat_t lastBeat;
    logic serveFetch;

    // read latency tracking
    logic capFlag;
    memPkg::beat_t capBeat;

    logic fetchDoneReg;
    logic dataDoneReg;

    logic acceptOk;
    logic takeData;
    logic takeFetch;
    logic readIssue;

    // last beat index for a data access
    function automatic memPkg::beat_t lenToLast(input memPkg::accessLen_t len);
        memPkg::beat_t last;
        case (len)
            memPkg::lenByte: last = 2'd0;
            memPkg::lenHalf: last = 2'd1;
            default:         last = 2'd3;
        endcase
        return last;
    endfunction

    // no new request while a done pulse is still pending
    assign acceptOk  = (state == memPkg::idle) && !fetchDoneReg && !dataDoneReg && !i_stall;
    assign takeData  = acceptOk && i_dataEn;
    assign takeFetch = acceptOk && !i_dataEn && i_fetchEn;

    assign readIssue = (state == memPkg::fetchRead) || (state == memPkg::loadRead);

    assign o_ramEn      = (readIssue || (state == memPkg::storeWrite)) && !i_stall;
    assign o_ramWe      = (state == memPkg::storeWrite) && !i_stall;
    assign o_ramAddr    = baseAddr + AddrWidth'(beat);
    assign o_issueBeat  = beat;

    assign o_captureEn   = capFlag && !i_stall;
    assign o_captureBeat = capBeat;

    assign o_clearWord  = takeFetch || (takeData && !i_dataStore);
    assign o_latchStore = takeData && i_dataStore;

    // held through a stall and shown once it lifts
    assign o_fetchDone = fetchDoneReg && !i_stall;
    assign o_dataDone  = dataDoneReg && !i_stall;

    always_ff @(posedge clk) begin
        if (takeData) begin
            baseAddr <= i_dataAddr;
        end else if (takeFetch) begin
            baseAddr <= i_fetchAddr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= memPkg::idle;
            beat         <= '0;
            lastBeat     <= '0;
            serveFetch   <= 1'b0;
            capFlag      <= 1'b0;
            capBeat      <= '0;
            fetchDoneReg <= 1'b0;
            dataDoneReg  <= 1'b0;
        end else if (!i_stall) begin
            fetchDoneReg <= 1'b0;
            dataDoneReg  <= 1'b0;
            // byte lands in the RAM register one cycle after its address
            capFlag      <= readIssue;
            capBeat      <= beat;

            case (state)
                memPkg::idle: begin
                    beat <= '0;
                    if (takeData) begin
                        state      <= i_dataStore ? memPkg::storeWrite : memPkg::loadRead;
                        lastBeat   <= lenToLast(i_dataLen);
                        serveFetch <= 1'b0;
                    end else if (takeFetch) begin
                        state      <= memPkg::fetchRead;
                        lastBeat   <= 2'd3;
                        serveFetch <= 1'b1;
                    end
                end
                memPkg::fetchRead,
                memPkg::loadRead: begin
                    if (beat == lastBeat) begin
                        state <= memPkg::finish;
                        beat  <= '0;
                    end else begin
                        beat <= beat + 2'd1;
                    end
                end
                memPkg::storeWrite: begin
                    // no read latency, so done follows the last write directly
                    if (beat == lastBeat) begin
                        state       <= memPkg::idle;
                        beat        <= '0;
                        dataDoneReg <= 1'b1;
                    end else begin
                        beat <= beat + 2'd1;
                    end
                end
                memPkg::finish: begin
                    state <= memPkg::idle;
                    if (serveFetch) begin
                        fetchDoneReg <= 1'b1;
                    end else begin
                        dataDoneReg <= 1'b1;
                    end
                end
                default: begin
                    state <= memPkg::idle;
                end
            endcase
        end
    end

    doneExclusive: assert property (@(posedge clk) disable iff (rst)
        !(o_fetchDone && o_dataDone))
        else $error("fetch and data done high in the same cycle");

    // writes stay within the beats of the store the client is holding
    writeOnlyInStore: assert property (@(posedge clk) disable iff (rst)
        o_ramWe |-> (state == memPkg::storeWrite) && !serveFetch
                    && (beat <= lenToLast(i_dataLen)))
        else $error("RAM write outside the beats of a store access");

    stallFreezes: assert property (@(posedge clk) disable iff (rst)
        i_stall |=> $stable(state) && $stable(beat) && $stable(capFlag)
                    && $stable(fetchDoneReg) && $stable(dataDoneReg))
        else $error("controller moved during a stall");

endmodule

`default_nettype wire

// File: source/loadAssembler.sv
`timescale 1ns/1ns
`default_nettype none

module loadAssembler (
    input  wire             clk,
    input  wire             rst,
    input  wire             i_clear,
    input  wire             i_captureEn,
    input  memPkg::beat_t   i_captureBeat,
    input  memPkg::byte_t   i_ramByte,
    output memPkg::word_t   o_word
);

    memPkg::byte_t lanes [4];

    // little-endian, lane 0 is the lowest address
    assign o_word = {lanes[3], lanes[2], lanes[1], lanes[0]};

    // untouched lanes stay zero after the clear
    always_ff @(posedge clk) begin
        if (rst || i_clear) begin
            for (int i = 0; i < 4; i++) begin
                lanes[i] <= '0;
            end
        end else if (i_captureEn) begin
            lanes[i_captureBeat] <= i_ramByte;
        end
    end

    clearNotCapture: assert property (@(posedge clk) disable iff (rst)
        !(i_clear && i_captureEn))
        else $error("new read accepted while a capture is still pending");

endmodule

`default_nettype wire

// File: source/storeSerializer.sv
`timescale 1ns/1ns
`default_nettype none

module storeSerializer (
    input  wire             clk,
    input  wire             rst,
    input  wire             i_latch,
    input  memPkg::word_t   i_storeWord,
    input  memPkg::beat_t   i_beat,
    output memPkg::byte_t   o_byte
);

    memPkg::word_t storeWord;

    // frozen for the whole access
    always_ff @(posedge clk) begin
        if (rst) begin
            storeWord <= '0;
        end else if (i_latch) begin
            storeWord <= i_storeWord;
        end
    end

    // lane for the beat being written
    assign o_byte = storeWord[{i_beat, 3'b000} +: 8];

endmodule

`default_nettype wire

// File: source/byteRam.sv
`timescale 1ns/1ns
`default_nettype none

module byteRam #(
    parameter int AddrWidth = 12
) (
    input  wire                   clk,
    input  wire                   i_en,
    input  wire                   i_we,
    input  wire [AddrWidth-1:0]   i_addr,
    input  memPkg::byte_t         i_wrByte,
    output memPkg::byte_t         o_rdByte
);

    localparam int Depth = 1 << AddrWidth;

    memPkg::byte_t mem [Depth];

    always_ff @(posedge clk) begin
        if (i_en && i_we) begin
            mem[i_addr] <= i_wrByte;
        end
    end

    // read register holds its byte while disabled
    always_ff @(posedge clk) begin
        if (i_en) begin
            o_rdByte <= mem[i_addr];
        end
    end

    addrKnown: assert property (@(posedge clk)
        i_en |-> !$isunknown(i_addr))
        else $error("unknown RAM address while enabled");

endmodule

`default_nettype wire

// File: source/memSubsystem.sv
`timescale 1ns/1ns
`default_nettype none

module memSubsystem #(
    parameter int AddrWidth = 12
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   i_stall,
    input  wire                   i_fetchEn,
    input  wire [AddrWidth-1:0]   i_fetchAddr,
    input  wire                   i_dataEn,
    input  wire                   i_dataStore,
    input  memPkg::accessLen_t    i_dataLen,
    input  wire [AddrWidth-1:0]   i_dataAddr,
    input  memPkg::word_t         i_dataWr,
    output logic                  o_fetchDone,
    output memPkg::word_t         o_fetchInst,
    output logic                  o_dataDone,
    output memPkg::word_t         o_loadData
);

    logic ramEn;
    logic ramWe;
    logic [AddrWidth-1:0] ramAddr;
    memPkg::beat_t issueBeat;
    logic captureEn;
    memPkg::beat_t captureBeat;
    logic clearWord;
    logic latchStore;
    memPkg::byte_t rdByte;
    memPkg::byte_t wrByte;
    memPkg::word_t asmWord;

    memCtrl #(
        .AddrWidth(AddrWidth)
    ) ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .i_stall      (i_stall),
        .i_fetchEn    (i_fetchEn),
        .i_fetchAddr  (i_fetchAddr),
        .i_dataEn     (i_dataEn),
        .i_dataStore  (i_dataStore),
        .i_dataLen    (i_dataLen),
        .i_dataAddr   (i_dataAddr),
        .o_ramEn      (ramEn),
        .o_ramWe      (ramWe),
        .o_ramAddr    (ramAddr),
        .o_issueBeat  (issueBeat),
        .o_captureEn  (captureEn),
        .o_captureBeat(captureBeat),
        .o_clearWord  (clearWord),
        .o_latchStore (latchStore),
        .o_fetchDone  (o_fetchDone),
        .o_dataDone   (o_dataDone)
    );

    loadAssembler asm_i (
        .clk          (clk),
        .rst          (rst),
        .i_clear      (clearWord),
        .i_captureEn  (captureEn),
        .i_captureBeat(captureBeat),
        .i_ramByte    (rdByte),
        .o_word       (asmWord)
    );

    storeSerializer ser_i (
        .clk        (clk),
        .rst        (rst),
        .i_latch    (latchStore),
        .i_storeWord(i_dataWr),
        .i_beat     (issueBeat),
        .o_byte     (wrByte)
    );

    byteRam #(
        .AddrWidth(AddrWidth)
    ) ram_i (
        .clk     (clk),
        .i_en    (ramEn),
        .i_we    (ramWe),
        .i_addr  (ramAddr),
        .i_wrByte(wrByte),
        .o_rdByte(rdByte)
    );

    // one assembler serves both clients
    assign o_fetchInst = asmWord;
    assign o_loadData  = asmWord;

endmodule

`default_nettype wire

// File: verif/memSubsystemTb.sv
`timescale 1ns/1ns
`default_nettype none

module memSubsystemTb;

    localparam int AddrWidth = 12;
    // about 200 transactions of up to 7 cycles, plus up to 8 stalls each, plus reset
    localparam int CycleLimit = 4000;
    localparam int RandomCount = 120;
    localparam logic [AddrWidth-1:0] RegionBase = 12'hFE0;

    logic clk;
    logic rst;
    logic stall;
    logic fetchEn;
    logic [AddrWidth-1:0] fetchAddr;
    logic dataEn;
    logic dataStore;
    memPkg::accessLen_t dataLen;
    logic [AddrWidth-1:0] dataAddr;
    memPkg::word_t dataWr;
    logic fetchDone;
    memPkg::word_t fetchInst;
    logic dataDone;
    memPkg::word_t loadData;

    int errors = 0;
    int cycles = 0;
    int seed;
    int stallCount;
    logic stallOn;
    string testName;

    // reference memory and the transaction in flight
    memPkg::byte_t refMem [1 << AddrWidth];
    logic busy;
    logic doneDue;
    logic dueFetch;
    logic curStore;
    int remain;
    logic [AddrWidth-1:0] curAddr;
    int curLen;
    memPkg::word_t curWr;
    memPkg::word_t expWord;

    memSubsystem #(
        .AddrWidth(AddrWidth)
    ) dut_i (
        .clk        (clk),
        .rst        (rst),
        .i_stall    (stall),
        .i_fetchEn  (fetchEn),
        .i_fetchAddr(fetchAddr),
        .i_dataEn   (dataEn),
        .i_dataStore(dataStore),
        .i_dataLen  (dataLen),
        .i_dataAddr (dataAddr),
        .i_dataWr   (dataWr),
        .o_fetchDone(fetchDone),
        .o_fetchInst(fetchInst),
        .o_dataDone (dataDone),
        .o_loadData (loadData)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int lenBytes(input memPkg::accessLen_t len);
        int n;
        case (len)
            memPkg::lenByte: n = 1;
            memPkg::lenHalf: n = 2;
            default:         n = 4;
        endcase
        return n;
    endfunction

    // little-endian, upper bytes zero
    function automatic memPkg::word_t modelWord(input logic [AddrWidth-1:0] addr, input int n);
        memPkg::word_t w;
        w = '0;
        for (int k = 0; k < n; k++) begin
            w[8*k +: 8] = refMem[AddrWidth'(addr + k)];
        end
        return w;
    endfunction

    function automatic logic nextStall();
        logic s;
        s = 1'b0;
        if (stallOn && stallCount < 8 && ({$random(seed)} % 4) == 0) begin
            s = 1'b1;
            stallCount++;
        end
        return s;
    endfunction

    // expected acceptance, latency and store effect
    always @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            doneDue <= 1'b0;
            remain  <= 0;
        end else if (!stall) begin
            if (!busy) begin
                if (dataEn || fetchEn) begin
                    busy     <= 1'b1;
                    dueFetch <= !dataEn;
                    curStore <= dataEn && dataStore;
                    curAddr  <= dataEn ? dataAddr : fetchAddr;
                    curLen   <= dataEn ? lenBytes(dataLen) : 4;
                    curWr    <= dataWr;
                    remain   <= (dataEn && dataStore) ? lenBytes(dataLen)
                                : (dataEn ? lenBytes(dataLen) + 1 : 5);
                    expWord  <= dataEn ? modelWord(dataAddr, lenBytes(dataLen))
                                : modelWord(fetchAddr, 4);
                end
            end else if (doneDue) begin
                doneDue <= 1'b0;
                busy    <= 1'b0;
            end else if (remain == 1) begin
                doneDue <= 1'b1;
                remain  <= 0;
                if (curStore) begin
                    for (int k = 0; k < 4; k++) begin
                        if (k < curLen) begin
                            refMem[AddrWidth'(curAddr + k)] <= curWr[8*k +: 8];
                        end
                    end
                end
            end else begin
                remain <= remain - 1;
            end
        end
    end

    dataDoneTiming: assert property (@(posedge clk) disable iff (rst)
        dataDone == (doneDue && !dueFetch && !stall))
        else begin
            errors++;
            $display("data done pulse at an unexpected cycle in test %s", testName);
        end

    fetchDoneTiming: assert property (@(posedge clk) disable iff (rst)
        fetchDone == (doneDue && dueFetch && !stall))
        else begin
            errors++;
            $display("fetch done pulse at an unexpected cycle in test %s", testName);
        end

    noDoneInStall: assert property (@(posedge clk) disable iff (rst)
        stall |-> !(dataDone || fetchDone))
        else begin
            errors++;
            $display("done pulse while stalled in test %s", testName);
        end

    doneExclusive: assert property (@(posedge clk) disable iff (rst)
        !(dataDone && fetchDone))
        else begin
            errors++;
            $display("both done outputs high in one cycle in test %s", testName);
        end

    loadValue: assert property (@(posedge clk) disable iff (rst)
        (dataDone && !curStore) |-> (loadData == expWord))
        else begin
            errors++;
            $display("Fail %s: expected %h, actual %h", testName,
                     $sampled(expWord), $sampled(loadData));
        end

    fetchValue: assert property (@(posedge clk) disable iff (rst)
        fetchDone |-> (fetchInst == expWord))
        else begin
            errors++;
            $display("Fail %s: expected %h, actual %h", testName,
                     $sampled(expWord), $sampled(fetchInst));
        end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", CycleLimit);
            $display("errors: %0d", errors);
            $display("Done: errors found");
            $finish;
        end
    end

    // hold requests until each done, then drop that enable
    task automatic runRequests(input logic useData, input logic useFetch);
        logic dataPending;
        logic fetchPending;
        logic dataSeen;
        logic fetchSeen;
        dataPending = useData;
        fetchPending = useFetch;
        dataEn = useData;
        fetchEn = useFetch;
        stallCount = 0;
        stall = nextStall();
        while (dataPending || fetchPending) begin
            @(negedge clk);
            dataSeen = dataDone;
            fetchSeen = fetchDone;
            @(posedge clk);
            #2;
            if (dataSeen) begin
                dataPending = 1'b0;
                dataEn = 1'b0;
            end
            if (fetchSeen) begin
                fetchPending = 1'b0;
                fetchEn = 1'b0;
            end
            stall = nextStall();
        end
        stall = 1'b0;
    endtask

    task automatic setData(input logic store, input memPkg::accessLen_t len,
                           input logic [AddrWidth-1:0] addr, input memPkg::word_t wr);
        dataStore = store;
        dataLen = len;
        dataAddr = addr;
        dataWr = wr;
    endtask

    task automatic dataAccess(input logic store, input memPkg::accessLen_t len,
                              input logic [AddrWidth-1:0] addr, input memPkg::word_t wr);
        setData(store, len, addr, wr);
        runRequests(1'b1, 1'b0);
    endtask

    task automatic fetchAccess(input logic [AddrWidth-1:0] addr);
        fetchAddr = addr;
        runRequests(1'b0, 1'b1);
    endtask

    task automatic dataAndFetch(input logic store, input memPkg::accessLen_t len,
                                input logic [AddrWidth-1:0] addr, input memPkg::word_t wr,
                                input logic [AddrWidth-1:0] instAddr);
        setData(store, len, addr, wr);
        fetchAddr = instAddr;
        runRequests(1'b1, 1'b1);
    endtask

    task automatic randomAccess();
        int mix;
        logic store;
        memPkg::accessLen_t len;
        logic [AddrWidth-1:0] addr;
        logic [AddrWidth-1:0] instAddr;
        memPkg::word_t wr;
        mix = {$random(seed)} % 4;
        store = ({$random(seed)} % 2) == 1;
        case ({$random(seed)} % 3)
            0:       len = memPkg::lenByte;
            1:       len = memPkg::lenHalf;
            default: len = memPkg::lenWord;
        endcase
        // offsets up to 60 keep word accesses inside the filled region
        addr = RegionBase + AddrWidth'({$random(seed)} % 61);
        instAddr = RegionBase + AddrWidth'({$random(seed)} % 61);
        wr = $random(seed);
        if (mix == 0) begin
            fetchAccess(instAddr);
        end else if (mix == 2) begin
            dataAndFetch(store, len, addr, wr, instAddr);
        end else begin
            dataAccess(store, len, addr, wr);
        end
    endtask

    initial begin
        logic [AddrWidth-1:0] addr;
        seed = 32'h2857;
        stallOn = 1'b0;
        stallCount = 0;
        testName = "reset";
        rst = 1'b1;
        stall = 1'b0;
        fetchEn = 1'b0;
        fetchAddr = '0;
        dataEn = 1'b0;
        dataStore = 1'b0;
        dataLen = memPkg::lenByte;
        dataAddr = '0;
        dataWr = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        // quiet window before the first request
        repeat (4) @(posedge clk);
        #2;

        // region wraps from the top of the RAM to address 0
        testName = "fill";
        for (int i = 0; i < 16; i++) begin
            dataAccess(1'b1, memPkg::lenWord, RegionBase + AddrWidth'(4 * i), $random(seed));
        end

        testName = "wordStoreLoad";
        addr = RegionBase + 12'd8;
        dataAccess(1'b1, memPkg::lenWord, addr, $random(seed));
        dataAccess(1'b0, memPkg::lenWord, addr, '0);
        fetchAccess(addr);

        testName = "byteHalf";
        addr = RegionBase + 12'd21;
        dataAccess(1'b1, memPkg::lenByte, addr, $random(seed));
        dataAccess(1'b0, memPkg::lenWord, addr, '0);
        dataAccess(1'b0, memPkg::lenByte, addr, '0);
        addr = 12'hFFF;
        dataAccess(1'b1, memPkg::lenHalf, addr, $random(seed));
        dataAccess(1'b0, memPkg::lenWord, addr, '0);
        dataAccess(1'b0, memPkg::lenHalf, addr, '0);

        testName = "arbitration";
        dataAndFetch(1'b0, memPkg::lenHalf, RegionBase + 12'd30, '0, RegionBase + 12'd40);
        dataAndFetch(1'b1, memPkg::lenWord, RegionBase + 12'd40, $random(seed),
                     RegionBase + 12'd40);

        testName = "randomStall";
        stallOn = 1'b1;
        repeat (RandomCount) begin
            randomAccess();
        end
        stallOn = 1'b0;

        repeat (4) @(posedge clk);
        #2;
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
source/memPkg.sv
source/memCtrl.sv
source/loadAssembler.sv
source/storeSerializer.sv
source/byteRam.sv
source/memSubsystem.sv
verif/memSubsystemTb.sv
